// ==== Makefile ====
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing --assert
TOP        = clint_tb
FILELIST   = verilog.f
PASS_MSG   = Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== rtl/clint_pkg.sv ====
`default_nettype none

package clint_pkg;

  // Register select taken from address bits 5:4
  //   msip      0x00
  //   mtime     0x10 low, 0x50 high
  //   mtimecmp  0x20 low, 0x60 high
  typedef enum logic [1:0] {
    MSIP     = 2'd0,
    MTIME    = 2'd1,
    MTIMECMP = 2'd2,
    NONE     = 2'd3
  } csr_sel_e;

  // Address bit picking the upper 32-bit half
  localparam int HALF_BIT = 6;

  // Bus clocks per mtime increment
  localparam int TICK_DIV = 100;

  localparam int MTIME_W = 64;

endpackage

`default_nettype wire

// ==== rtl/clint_top.sv ====
`default_nettype none

module clint_top (
  input  wire                          wb_if_s,
  input  wire                          rst_n,
  input  wire                          cyc,
  input  wire                          stb,
  input  wire                          we,
  input  wire  [wb_pkg::WB_ADDR_W-1:0] addr,
  input  wire  [wb_pkg::WB_DATA_W-1:0] dat_i,
  output logic [wb_pkg::WB_DATA_W-1:0] dat_o,
  output logic                         ack,
  output logic [clint_pkg::MTIME_W-1:0] mtime,
  output logic                         timer_irq,
  output logic                         soft_irq
);

  import wb_pkg::*;
  import clint_pkg::*;

  logic [WB_DATA_W-1:0] msip;
  logic [MTIME_W-1:0]   mtimecmp;

  wishbone_if bus (
    .wb_if_s(wb_if_s),
    .rst_n  (rst_n)
  );

  // Request side from the pins
  assign bus.cyc     = cyc;
  assign bus.stb     = stb;
  assign bus.we      = we;
  assign bus.addr    = addr;
  assign bus.dat_i_s = dat_i;

  // Response side to the pins
  assign dat_o = bus.dat_o_s;
  assign ack   = bus.ack;

  csr_mem csr_mem_i (
    .bus     (bus.secondary),
    .msip    (msip),
    .mtime   (mtime),
    .mtimecmp(mtimecmp)
  );

  // Only msip bit 0 is wired as the software interrupt
  irq_gen irq_gen_i (
    .wb_if_s  (wb_if_s),
    .rst_n    (rst_n),
    .mtime    (mtime),
    .mtimecmp (mtimecmp),
    .msip_bit (msip[0]),
    .timer_irq(timer_irq),
    .soft_irq (soft_irq)
  );

endmodule

`default_nettype wire

// ==== rtl/csr_mem.sv ====
`default_nettype none

module csr_mem #(
  parameter int clock_cycles = clint_pkg::TICK_DIV
) (
  wishbone_if.secondary                 bus,
  output logic [wb_pkg::WB_DATA_W-1:0]  msip,
  output logic [clint_pkg::MTIME_W-1:0] mtime,
  output logic [clint_pkg::MTIME_W-1:0] mtimecmp
);

  import wb_pkg::*;
  import clint_pkg::*;

  csr_sel_e                        sel;
  logic                            hi_half;
  logic                            rd_en;
  logic                            wr_en;
  logic                            ack_q;
  logic                            tick;
  logic [$clog2(clock_cycles)-1:0] cycles;
  logic [MTIME_W-1:0]              mtime_load;
  logic [MTIME_W-1:0]              mtimecmp_d;

  always_comb begin
    rd_en = bus.rd_en();
    wr_en = bus.wr_en();
  end

  // Address decode
  assign sel     = csr_sel_e'(bus.addr[5:4]);
  assign hi_half = bus.addr[HALF_BIT];

  // A 32-bit write replaces one half and keeps the other
  always_comb begin
    if (hi_half) begin
      mtime_load = {bus.dat_i_s, mtime[WB_DATA_W-1:0]};
      mtimecmp_d = {bus.dat_i_s, mtimecmp[WB_DATA_W-1:0]};
    end else begin
      mtime_load = {mtime[MTIME_W-1:WB_DATA_W], bus.dat_i_s};
      mtimecmp_d = {mtimecmp[MTIME_W-1:WB_DATA_W], bus.dat_i_s};
    end
  end

  // msip
  always_ff @(posedge bus.wb_if_s) begin
    if (!bus.rst_n) begin
      msip <= '0;
    end else if (wr_en && sel == MSIP) begin
      msip <= bus.dat_i_s;
    end
  end

  // mtimecmp
  always_ff @(posedge bus.wb_if_s) begin
    if (!bus.rst_n) begin
      mtimecmp <= '0;
    end else if (wr_en && sel == MTIMECMP) begin
      mtimecmp <= mtimecmp_d;
    end
  end

  // Prescaler wraps to zero on the tick
  sync_parallel_counter #(
    .width($clog2(clock_cycles))
  ) tick_counter (
    .wb_if_s   (bus.wb_if_s),
    .rst_n     (bus.rst_n),
    .load      (tick),
    .load_value('0),
    .inc_enable(1'b1),
    .dec_enable(1'b0),
    .value     (cycles)
  );

  assign tick = (int'(cycles) == clock_cycles - 1);

  // Bus load takes priority over the tick
  sync_parallel_counter #(
    .width(MTIME_W)
  ) mtime_counter (
    .wb_if_s   (bus.wb_if_s),
    .rst_n     (bus.rst_n),
    .load      (wr_en && sel == MTIME),
    .load_value(mtime_load),
    .inc_enable(tick),
    .dec_enable(1'b0),
    .value     (mtime)
  );

  // Read mux, valid while the primary holds addr through ack
  always_comb begin
    case (sel)
      MSIP:     bus.dat_o_s = msip;
      MTIME:    bus.dat_o_s = hi_half ? mtime[MTIME_W-1:WB_DATA_W]
                                      : mtime[WB_DATA_W-1:0];
      MTIMECMP: bus.dat_o_s = hi_half ? mtimecmp[MTIME_W-1:WB_DATA_W]
                                      : mtimecmp[WB_DATA_W-1:0];
      default:  bus.dat_o_s = '0;
    endcase
  end

  // Single-cycle ack; a held request is answered again after a low cycle
  always_ff @(posedge bus.wb_if_s) begin
    if (!bus.rst_n || ack_q) begin
      ack_q <= 1'b0;
    end else if (rd_en || wr_en) begin
      ack_q <= 1'b1;
    end
  end

  assign bus.ack = ack_q;

endmodule

`default_nettype wire

// ==== rtl/irq_gen.sv ====
`default_nettype none

module irq_gen (
  input  wire                          wb_if_s,
  input  wire                          rst_n,
  input  wire [clint_pkg::MTIME_W-1:0] mtime,
  input  wire [clint_pkg::MTIME_W-1:0] mtimecmp,
  input  wire                          msip_bit,
  output logic                         timer_irq,
  output logic                         soft_irq
);

  // Unsigned compare, registered so the hart sees clean levels
  always_ff @(posedge wb_if_s) begin
    if (!rst_n) begin
      timer_irq <= 1'b0;
      soft_irq  <= 1'b0;
    end else begin
      timer_irq <= (mtime >= mtimecmp);
      soft_irq  <= msip_bit;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/sync_parallel_counter.sv ====
`default_nettype none

module sync_parallel_counter #(
  parameter int width = 8
) (
  input  wire              wb_if_s,
  input  wire              rst_n,
  input  wire              load,
  input  wire  [width-1:0] load_value,
  input  wire              inc_enable,
  input  wire              dec_enable,
  output logic [width-1:0] value
);

  // Load beats counting; equal enables hold
  always_ff @(posedge wb_if_s) begin
    if (!rst_n) begin
      value <= '0;
    end else if (load) begin
      value <= load_value;
    end else if (inc_enable && !dec_enable) begin
      value <= value + 1'b1;
    end else if (dec_enable && !inc_enable) begin
      value <= value - 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/wb_pkg.sv ====
`default_nettype none

package wb_pkg;

  // Bus widths, byte addressed
  localparam int WB_ADDR_W = 8;
  localparam int WB_DATA_W = 32;

  // Kind of the cycle currently on the bus
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    READ  = 2'd1,
    WRITE = 2'd2
  } wb_cycle_e;

endpackage

`default_nettype wire

// ==== rtl/wishbone_if.sv ====
`default_nettype none

interface wishbone_if (
  input wire wb_if_s,
  input wire rst_n
);

  import wb_pkg::*;

  logic                 cyc;
  logic                 stb;
  logic                 we;
  logic [WB_ADDR_W-1:0] addr;
  logic [WB_DATA_W-1:0] dat_i_s;
  logic [WB_DATA_W-1:0] dat_o_s;
  logic                 ack;

  function automatic wb_cycle_e cycle_kind();
    wb_cycle_e kind;
    if (cyc && stb) begin
      kind = we ? WRITE : READ;
    end else begin
      kind = IDLE;
    end
    return kind;
  endfunction

  function automatic logic rd_en();
    return cycle_kind() == READ;
  endfunction

  function automatic logic wr_en();
    return cycle_kind() == WRITE;
  endfunction

  modport primary (
    input  wb_if_s, rst_n, dat_o_s, ack,
    output cyc, stb, we, addr, dat_i_s
  );

  modport secondary (
    input  wb_if_s, rst_n, cyc, stb, we, addr, dat_i_s,
    output dat_o_s, ack,
    import rd_en, wr_en
  );

endinterface

`default_nettype wire

// ==== verification/clint_assert.sv ====
`default_nettype none

module clint_assert (
  input wire                          wb_if_s,
  input wire                          rst_n,
  input wire                          cyc,
  input wire                          stb,
  input wire                          ack,
  input wire [clint_pkg::MTIME_W-1:0] mtime,
  input wire [clint_pkg::MTIME_W-1:0] mtimecmp,
  input wire                          timer_irq
);

  // Ack lasts exactly one cycle
  ack_single: assert property (@(posedge wb_if_s) disable iff (!rst_n)
    ack |=> !ack)
    else $error("ack high for two cycles in a row");

  ack_after_req: assert property (@(posedge wb_if_s) disable iff (!rst_n)
    ack |-> $past(cyc && stb))
    else $error("ack without a request in the previous cycle");

  // Registered compare, skipped on the first cycle out of reset
  timer_follows_cmp: assert property (@(posedge wb_if_s) disable iff (!rst_n)
    $past(rst_n) |-> timer_irq == $past(mtime >= mtimecmp))
    else $error("timer_irq does not follow mtime >= mtimecmp");

endmodule

bind clint_top clint_assert clint_assert_i (
  .wb_if_s  (wb_if_s),
  .rst_n    (rst_n),
  .cyc      (cyc),
  .stb      (stb),
  .ack      (ack),
  .mtime    (mtime),
  .mtimecmp (mtimecmp),
  .timer_irq(timer_irq)
);

`default_nettype wire

// ==== verification/clint_stimulus.txt ====
# op addr data expect (hex). W/H write (H held over two acks), R read = expect,
# T read in expect..expect+data, N wait data cycles, I timer_irq = data, soft_irq = expect
R 00 00000000 00000000
R 10 00000000 00000000
R 50 00000000 00000000
R 20 00000000 00000000
R 60 00000000 00000000
R 30 00000000 00000000
R 70 00000000 00000000
I 00 00000001 00000000
W 00 a5a5a5a5 00000000
R 00 00000000 a5a5a5a5
I 00 00000001 00000001
W 00 00000002 00000000
I 00 00000001 00000000
R 00 00000000 00000002
W 00 00000000 00000000
R 00 00000000 00000000
W 20 12345678 00000000
W 60 9abcdef0 00000000
R 20 00000000 12345678
R 60 00000000 9abcdef0
W 20 0badf00d 00000000
R 60 00000000 9abcdef0
R 20 00000000 0badf00d
W 60 00000001 00000000
R 20 00000000 0badf00d
R 60 00000000 00000001
I 00 00000000 00000000
W 50 00000001 00000000
W 10 00001000 00000000
T 10 00000001 00001000
R 50 00000000 00000001
N 00 000003e8 00000000
T 10 00000001 0000100a
R 50 00000000 00000001
I 00 00000000 00000000
W 20 00001000 00000000
I 00 00000001 00000000
W 60 00000002 00000000
I 00 00000000 00000000
H 20 00000777 00000000
R 20 00000000 00000777
R 60 00000000 00000002
H 00 00000001 00000000
I 00 00000000 00000001
R 00 00000000 00000001
W 00 00000000 00000000
I 00 00000000 00000000

// ==== verification/clint_tb.sv ====
`default_nettype none

module clint_tb;

  import wb_pkg::*;
  import clint_pkg::*;

  logic                 wb_if_s;
  logic                 rst_n;
  logic                 cyc;
  logic                 stb;
  logic                 we;
  logic [WB_ADDR_W-1:0] addr;
  logic [WB_DATA_W-1:0] dat_i;
  logic [WB_DATA_W-1:0] dat_o;
  logic                 ack;
  logic [MTIME_W-1:0]   mtime;
  logic                 timer_irq;
  logic                 soft_irq;

  // One entry per stimulus line
  byte                  op_q[$];
  logic [WB_ADDR_W-1:0] addr_q[$];
  logic [WB_DATA_W-1:0] data_q[$];
  logic [WB_DATA_W-1:0] exp_q[$];

  // mtime pin as seen in the last ack cycle
  logic [MTIME_W-1:0]   mtime_ack;

  int checks;
  int errors;
  int limit_cycles;

  clint_top clint_top_i (
    .wb_if_s  (wb_if_s),
    .rst_n    (rst_n),
    .cyc      (cyc),
    .stb      (stb),
    .we       (we),
    .addr     (addr),
    .dat_i    (dat_i),
    .dat_o    (dat_o),
    .ack      (ack),
    .mtime    (mtime),
    .timer_irq(timer_irq),
    .soft_irq (soft_irq)
  );

  always #50 wb_if_s = ~wb_if_s;

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    errors++;
    $display("Error at %0t: %s expected %h, actual %h", $time, name, expected, actual);
  endtask

  task automatic check_range(input string name, input logic [31:0] low,
                             input logic [31:0] span, input logic [31:0] actual);
    checks++;
    if (actual < low || actual > low + span) begin
      errors++;
      $display("Error at %0t: %s expected %h to %h, actual %h", $time, name,
               low, low + span, actual);
    end
  endtask

  // Half of the mtime pin that a read of this address returns
  function automatic logic [WB_DATA_W-1:0] mtime_half(input logic [WB_ADDR_W-1:0] a);
    return a[HALF_BIT] ? mtime_ack[MTIME_W-1:WB_DATA_W] : mtime_ack[WB_DATA_W-1:0];
  endfunction

  task automatic print_counts();
    $display("Checks run: %0d, errors: %0d", checks, errors);
  endtask

  task automatic load_stimulus();
    int                   fd;
    int                   got;
    int                   fields;
    string                line;
    byte                  op;
    logic [WB_ADDR_W-1:0] a;
    logic [WB_DATA_W-1:0] d;
    logic [WB_DATA_W-1:0] e;
    fd = $fopen("verification/clint_stimulus.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open verification/clint_stimulus.txt");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      got = $fgets(line, fd);
      if (got == 0 || line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n") begin
        continue;
      end
      fields = $sscanf(line, "%c %h %h %h", op, a, d, e);
      if (fields != 4) begin
        errors++;
        $display("Stimulus line could not be parsed: %s", line);
        continue;
      end
      op_q.push_back(op);
      addr_q.push_back(a);
      data_q.push_back(d);
      exp_q.push_back(e);
    end
    $fclose(fd);
    if (op_q.size() == 0) begin
      errors++;
      $display("Stimulus file holds no operations");
    end
  endtask

  // Wishbone primary; acks is 2 when the request is held over a second ack
  task automatic bus_access(input wb_cycle_e kind, input logic [WB_ADDR_W-1:0] a,
                            input logic [WB_DATA_W-1:0] d, input int acks,
                            output logic [WB_DATA_W-1:0] rdata);
    int waited;
    int seen;
    @(posedge wb_if_s);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= (kind == WRITE);
    addr  <= a;
    dat_i <= d;
    seen   = 0;
    waited = 0;
    rdata  = '0;
    while (seen < acks && waited < 8) begin
      @(posedge wb_if_s);
      waited++;
      if (ack === 1'b1) begin
        seen++;
        rdata     = dat_o;
        mtime_ack = mtime;
      end
    end
    if (seen < acks) begin
      errors++;
      $display("No ack at %0t for address %h, %0d of %0d acks seen", $time, a, seen, acks);
    end
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
    @(posedge wb_if_s);
    checks++;
    if (ack !== 1'b0) begin
      report_mismatch("ack", 32'd0, 32'(ack));
    end
  endtask

  task automatic run_op(input int idx);
    logic [WB_DATA_W-1:0] rdata;
    string                name;
    name = $sformatf("dat_o (addr %h)", addr_q[idx]);
    case (op_q[idx])
      "W": bus_access(WRITE, addr_q[idx], data_q[idx], 1, rdata);
      "H": bus_access(WRITE, addr_q[idx], data_q[idx], 2, rdata);
      "R": begin
        bus_access(READ, addr_q[idx], data_q[idx], 1, rdata);
        checks++;
        if (rdata !== exp_q[idx]) begin
          report_mismatch(name, exp_q[idx], rdata);
        end
        if (csr_sel_e'(addr_q[idx][5:4]) == MTIME) begin
          checks++;
          if (mtime_half(addr_q[idx]) !== exp_q[idx]) begin
            report_mismatch("mtime", exp_q[idx], mtime_half(addr_q[idx]));
          end
        end
      end
      "T": begin
        bus_access(READ, addr_q[idx], data_q[idx], 1, rdata);
        check_range(name, exp_q[idx], data_q[idx], rdata);
        check_range("mtime", exp_q[idx], data_q[idx], mtime_half(addr_q[idx]));
      end
      "N": repeat (data_q[idx]) @(posedge wb_if_s);
      "I": begin
        @(posedge wb_if_s);
        checks += 2;
        if (timer_irq !== data_q[idx][0]) begin
          report_mismatch("timer_irq", 32'(data_q[idx][0]), 32'(timer_irq));
        end
        if (soft_irq !== exp_q[idx][0]) begin
          report_mismatch("soft_irq", 32'(exp_q[idx][0]), 32'(soft_irq));
        end
      end
      default: begin
        errors++;
        $display("Unknown operation %c on stimulus entry %0d", op_q[idx], idx);
      end
    endcase
  endtask

  initial begin
    wb_if_s      = 1'b0;
    rst_n        = 1'b0;
    cyc          = 1'b0;
    stb          = 1'b0;
    we           = 1'b0;
    addr         = '0;
    dat_i        = '0;
    mtime_ack    = '0;
    checks       = 0;
    errors       = 0;
    limit_cycles = 0;
    load_stimulus();
    // Two prescaler periods per line on top of reset
    limit_cycles = op_q.size() * 2 * TICK_DIV + 8;
    repeat (8) @(posedge wb_if_s);
    rst_n <= 1'b1;
    foreach (op_q[i]) begin
      run_op(i);
    end
    print_counts();
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge wb_if_s);
    $display("Watchdog expired after %0d cycles before the stimulus finished", limit_cycles);
    print_counts();
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
rtl/wb_pkg.sv
rtl/clint_pkg.sv
rtl/wishbone_if.sv
rtl/sync_parallel_counter.sv
rtl/csr_mem.sv
rtl/irq_gen.sv
rtl/clint_top.sv
verification/clint_assert.sv
verification/clint_tb.sv
